// File: common/axiPkg.sv
`default_nettype none

package axiPkg;

    // bus widths
    localparam int axiDataW = 32;
    localparam int axiAddrW = 32;
    localparam int axiLenW  = 8;
    localparam int axiStrbW = axiDataW / 8;

    // fixed attributes, every transaction uses the same values
    // id 1, 4-byte beats, INCR bursts
    localparam logic [3:0] axiId        = 4'd1;
    localparam logic [2:0] axiSizeWord  = 3'b010;
    localparam logic [1:0] axiBurstIncr = 2'b01;

    // response codes on R and B
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axiResp;

endpackage

`default_nettype wire

// File: common/cacheBusPkg.sv
`default_nettype none

package cacheBusPkg;

    // line sizes in 32-bit words
    localparam int icLineWords = 16;
    localparam int dcLineWords = 8;

    localparam int readLineW  = icLineWords * 32;
    localparam int writeLineW = dcLineWords * 32;

    // word index widths
    localparam int icIdxW = $clog2(icLineWords);
    localparam int dcIdxW = $clog2(dcLineWords);

    // owner of the current read
    typedef enum logic {
        SRC_ICACHE = 1'b0,
        SRC_DCACHE = 1'b1
    } readSource;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } readState;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } writeState;

endpackage

`default_nettype wire

// File: common/readReqIf.sv
`timescale 1ns/1ps
`default_nettype none

interface readReqIf
    import axiPkg::*, cacheBusPkg::*;
();

    logic                reqValid;
    logic [axiAddrW-1:0] reqAddr;
    // AXI encoding, beats minus one
    logic [axiLenW-1:0]  reqLen;
    readSource           reqSource;
    logic                reqAccept;
    logic                reqDone;

    modport arbiter (
        output reqValid, reqAddr, reqLen, reqSource,
        input  reqAccept, reqDone
    );

    modport engine (
        input  reqValid, reqAddr, reqLen, reqSource,
        output reqAccept, reqDone
    );

endinterface

`default_nettype wire

// File: axiBridge/readArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module readArbiter
    import axiPkg::*, cacheBusPkg::*;
(
    input  logic                Clk,
    input  logic                rstN,
    input  logic                icReadReq,
    input  logic                icUncachedReq,
    input  logic [axiAddrW-1:0] icReadAddr,
    input  logic                dcReadReq,
    input  logic                dcUncachedReq,
    input  logic [axiAddrW-1:0] dcReadAddr,
    output logic                icReadAccept,
    output logic                dcReadAccept,
    readReqIf.arbiter           req
);

    logic                icAny;
    logic                dcAny;
    logic                locked;
    logic                accepted;
    readSource           selSource;
    readSource           lockSource;
    readSource           curSource;
    logic [axiAddrW-1:0] selAddr;
    logic [axiAddrW-1:0] lockAddr;
    logic [axiLenW-1:0]  selLen;
    logic [axiLenW-1:0]  lockLen;

    assign icAny = icReadReq | icUncachedReq;
    assign dcAny = dcReadReq | dcUncachedReq;

    // icache wins a tie
    always_comb begin
        if (icAny) begin
            selSource = SRC_ICACHE;
            selAddr   = icReadAddr;
            selLen    = icUncachedReq ? '0 : axiLenW'(icLineWords - 1);
        end else begin
            selSource = SRC_DCACHE;
            selAddr   = dcReadAddr;
            selLen    = dcUncachedReq ? '0 : axiLenW'(dcLineWords - 1);
        end
    end

    // live choice while idle, locked copy afterwards
    assign req.reqValid  = locked ? !accepted : (icAny | dcAny);
    assign req.reqAddr   = locked ? lockAddr : selAddr;
    assign req.reqLen    = locked ? lockLen : selLen;
    assign req.reqSource = curSource;
    assign curSource     = locked ? lockSource : selSource;

    assign icReadAccept = req.reqAccept && (curSource == SRC_ICACHE);
    assign dcReadAccept = req.reqAccept && (curSource == SRC_DCACHE);

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            locked   <= 1'b0;
            accepted <= 1'b0;
        end else if (req.reqDone) begin
            locked   <= 1'b0;
            accepted <= 1'b0;
        end else begin
            if (!locked && (icAny || dcAny)) begin
                locked <= 1'b1;
            end
            if (req.reqAccept) begin
                accepted <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!locked) begin
            lockAddr   <= selAddr;
            lockLen    <= selLen;
            lockSource <= selSource;
        end
    end

endmodule

`default_nettype wire

// File: axiBridge/axiReadEngine.sv
`timescale 1ns/1ps
`default_nettype none

module axiReadEngine
    import axiPkg::*, cacheBusPkg::*;
(
    input  logic                     Clk,
    input  logic                     rstN,
    readReqIf.engine                 req,
    output logic [axiAddrW-1:0]      Araddr,
    output logic [axiLenW-1:0]       Arlen,
    output logic                     Arvalid,
    input  logic                     Arready,
    input  logic [axiDataW-1:0]      Rdata,
    input  logic [1:0]               Rresp,
    input  logic                     Rlast,
    input  logic                     Rvalid,
    output logic                     Rready,
    output logic                     readDone,
    output cacheBusPkg::readSource   readSource,
    output logic [readLineW-1:0]     readLine,
    output logic                     readError,
    output logic                     readIdle
);

    readState             state;
    logic                 arFire;
    logic                 rFire;
    logic [icIdxW-1:0]    beatCnt;
    logic [readLineW-1:0] lineBuf;

    // address goes straight out with the granted request
    assign Arvalid = req.reqValid && (state != RD_DATA);
    assign Araddr  = req.reqAddr;
    assign Arlen   = req.reqLen;
    assign arFire  = Arvalid && Arready;

    assign Rready = (state == RD_DATA);
    assign rFire  = Rvalid && Rready;

    assign req.reqAccept = arFire;
    assign req.reqDone   = readDone;

    assign readLine = lineBuf;
    assign readIdle = (state == RD_IDLE) && !readDone;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state     <= RD_IDLE;
            readDone  <= 1'b0;
            readError <= 1'b0;
        end else begin
            readDone <= rFire && Rlast;
            case (state)
                RD_IDLE: begin
                    if (arFire) begin
                        state <= RD_DATA;
                    end else if (req.reqValid) begin
                        state <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (arFire) begin
                        state <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (rFire && Rlast) begin
                        state <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
            // sticky over the burst
            if (arFire) begin
                readError <= 1'b0;
            end else if (rFire && (axiResp'(Rresp) != OKAY)) begin
                readError <= 1'b1;
            end
        end
    end

    // beat collection, unfilled words stay zero
    always_ff @(posedge Clk) begin
        if (arFire) begin
            lineBuf    <= '0;
            beatCnt    <= '0;
            readSource <= req.reqSource;
        end else if (rFire) begin
            lineBuf[beatCnt * axiDataW +: axiDataW] <= Rdata;
            beatCnt <= beatCnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: axiBridge/axiWriteEngine.sv
`timescale 1ns/1ps
`default_nettype none

module axiWriteEngine
    import axiPkg::*, cacheBusPkg::*;
(
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic                  dcWriteReq,
    input  logic                  dcWriteUncached,
    input  logic [axiAddrW-1:0]   dcWriteAddr,
    input  logic [writeLineW-1:0] dcWriteLine,
    input  logic [axiStrbW-1:0]   dcWriteStrb,
    output logic                  dcWriteAccept,
    output logic [axiAddrW-1:0]   Awaddr,
    output logic [axiLenW-1:0]    Awlen,
    output logic                  Awvalid,
    input  logic                  Awready,
    output logic [axiDataW-1:0]   Wdata,
    output logic [axiStrbW-1:0]   Wstrb,
    output logic                  Wlast,
    output logic                  Wvalid,
    input  logic                  Wready,
    input  logic [1:0]            Bresp,
    input  logic                  Bvalid,
    output logic                  Bready,
    output logic                  writeDone,
    output logic                  writeError,
    output logic                  writeIdle
);

    writeState             state;
    logic                  awFire;
    logic                  wFire;
    logic                  bFire;
    logic [writeLineW-1:0] lineReg;
    logic [axiStrbW-1:0]   strbReg;
    logic [dcIdxW-1:0]     wordIdx;
    logic [dcIdxW-1:0]     lastIdx;

    // AW follows the request level until the slave takes it
    assign Awvalid = (dcWriteReq || dcWriteUncached)
                     && ((state == WR_IDLE) || (state == WR_ADDR));
    assign Awaddr  = dcWriteAddr;
    assign Awlen   = dcWriteUncached ? '0 : axiLenW'(dcLineWords - 1);
    assign awFire  = Awvalid && Awready;

    assign dcWriteAccept = awFire;

    // W payload comes from the captured line only
    assign Wvalid = (state == WR_DATA);
    assign Wdata  = lineReg[wordIdx * axiDataW +: axiDataW];
    assign Wstrb  = strbReg;
    assign Wlast  = Wvalid && (wordIdx == lastIdx);
    assign wFire  = Wvalid && Wready;

    assign Bready     = (state == WR_RESP);
    assign bFire      = Bvalid && Bready;
    assign writeDone  = bFire;
    assign writeError = bFire && (axiResp'(Bresp) != OKAY);

    assign writeIdle = (state == WR_IDLE);

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state   <= WR_IDLE;
            wordIdx <= '0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (awFire) begin
                        state <= WR_DATA;
                    end else if (Awvalid) begin
                        state <= WR_ADDR;
                    end
                    wordIdx <= '0;
                end
                WR_ADDR: begin
                    if (awFire) begin
                        state <= WR_DATA;
                    end
                    wordIdx <= '0;
                end
                WR_DATA: begin
                    if (wFire) begin
                        if (Wlast) begin
                            state <= WR_RESP;
                        end else begin
                            wordIdx <= wordIdx + 1'b1;
                        end
                    end
                end
                WR_RESP: begin
                    if (bFire) begin
                        state <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // line, strobe and beat count frozen for the burst
    always_ff @(posedge Clk) begin
        if (awFire) begin
            lineReg <= dcWriteLine;
            strbReg <= dcWriteUncached ? dcWriteStrb : '1;
            lastIdx <= Awlen[dcIdxW-1:0];
        end
    end

endmodule

`default_nettype wire

// File: hdl/cacheAxiBridge.sv
`timescale 1ns/1ps
`default_nettype none

module cacheAxiBridge
    import axiPkg::*, cacheBusPkg::*;
(
    input  logic                   Clk,
    input  logic                   rstN,
    // icache read
    input  logic                   icReadReq,
    input  logic                   icUncachedReq,
    input  logic [axiAddrW-1:0]    icReadAddr,
    output logic                   icReadAccept,
    // dcache read
    input  logic                   dcReadReq,
    input  logic                   dcUncachedReq,
    input  logic [axiAddrW-1:0]    dcReadAddr,
    output logic                   dcReadAccept,
    // dcache write
    input  logic                   dcWriteReq,
    input  logic                   dcWriteUncached,
    input  logic [axiAddrW-1:0]    dcWriteAddr,
    input  logic [writeLineW-1:0]  dcWriteLine,
    input  logic [axiStrbW-1:0]    dcWriteStrb,
    output logic                   dcWriteAccept,
    // completion back to the caches
    output logic                   readDone,
    output cacheBusPkg::readSource readSource,
    output logic [readLineW-1:0]   readLine,
    output logic                   readError,
    output logic                   readIdle,
    output logic                   writeDone,
    output logic                   writeError,
    output logic                   writeIdle,
    // AXI3 master
    output logic [axiAddrW-1:0]    Araddr,
    output logic [axiLenW-1:0]     Arlen,
    output logic                   Arvalid,
    input  logic                   Arready,
    input  logic [axiDataW-1:0]    Rdata,
    input  logic [1:0]             Rresp,
    input  logic                   Rlast,
    input  logic                   Rvalid,
    output logic                   Rready,
    output logic [axiAddrW-1:0]    Awaddr,
    output logic [axiLenW-1:0]     Awlen,
    output logic                   Awvalid,
    input  logic                   Awready,
    output logic [axiDataW-1:0]    Wdata,
    output logic [axiStrbW-1:0]    Wstrb,
    output logic                   Wlast,
    output logic                   Wvalid,
    input  logic                   Wready,
    input  logic [1:0]             Bresp,
    input  logic                   Bvalid,
    output logic                   Bready
);

    readReqIf readReq ();

    readArbiter i_readArbiter (
        .*,
        .req (readReq.arbiter)
    );

    axiReadEngine i_axiReadEngine (
        .*,
        .req (readReq.engine)
    );

    axiWriteEngine i_axiWriteEngine (
        .*
    );

endmodule

`default_nettype wire

// File: tb/cacheAxiBridge_props.sv
`timescale 1ns/1ps
`default_nettype none

module cacheAxiBridgeProps (
    input logic        Clk,
    input logic        rstN,
    input logic        valid,
    input logic        ready,
    input logic [63:0] payload,
    input logic        last,
    input logic        done
);

    logic busy;

    // from the handshake until completion
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            busy <= 1'b0;
        end else if (done) begin
            busy <= 1'b0;
        end else if (valid && ready) begin
            busy <= 1'b1;
        end
    end

    payloadHeld: assert property (@(posedge Clk) disable iff (!rstN)
        (valid && !ready) |=> (valid && $stable(payload)))
        else $error("valid or payload changed before ready");

    lastWithValid: assert property (@(posedge Clk) disable iff (!rstN) last |-> valid)
        else $error("last is high without valid");

    noRiseInFlight: assert property (@(posedge Clk) disable iff (!rstN)
        (busy && !done) |-> !$rose(valid))
        else $error("valid rose while a transaction was in flight");

endmodule

bind axiReadEngine cacheAxiBridgeProps i_readProps (
    .Clk     (Clk),
    .rstN    (rstN),
    .valid   (Arvalid),
    .ready   (Arready),
    .payload ({24'd0, Araddr, Arlen}),
    .last    (1'b0),
    .done    (readDone)
);

bind axiWriteEngine cacheAxiBridgeProps i_writeProps (
    .Clk     (Clk),
    .rstN    (rstN),
    .valid   (Wvalid),
    .ready   (Wready),
    .payload ({27'd0, Wdata, Wstrb, Wlast}),
    .last    (Wlast),
    .done    (writeDone)
);

`default_nettype wire

// File: tb/cacheAxiBridgeTb.sv
`timescale 1ns/1ps
`default_nettype none

module cacheAxiBridgeTb
    import axiPkg::*, cacheBusPkg::*;
();

    localparam int waitLimit = 500;
    localparam int maxTests  = 32;

    logic         Clk;
    logic         rstN;
    logic         icReadReq;
    logic         icUncachedReq;
    logic [31:0]  icReadAddr;
    logic         icReadAccept;
    logic         dcReadReq;
    logic         dcUncachedReq;
    logic [31:0]  dcReadAddr;
    logic         dcReadAccept;
    logic         dcWriteReq;
    logic         dcWriteUncached;
    logic [31:0]  dcWriteAddr;
    logic [255:0] dcWriteLine;
    logic [3:0]   dcWriteStrb;
    logic         dcWriteAccept;
    logic         readDone;
    readSource    doneSource;
    logic [511:0] readLine;
    logic         readError;
    logic         readIdle;
    logic         writeDone;
    logic         writeError;
    logic         writeIdle;
    logic [31:0]  Araddr;
    logic [31:0]  Awaddr;
    logic [31:0]  Wdata;
    logic [7:0]   Arlen;
    logic [7:0]   Awlen;
    logic [3:0]   Wstrb;
    logic         Arvalid;
    logic         Rready;
    logic         Awvalid;
    logic         Wvalid;
    logic         Wlast;
    logic         Bready;
    // slave outputs driven on the falling edge
    logic         Arready = 1'b0;
    logic [31:0]  Rdata = '0;
    logic [1:0]   Rresp = 2'b00;
    logic         Rlast = 1'b0;
    logic         Rvalid = 1'b0;
    logic         Awready = 1'b0;
    logic         Wready = 1'b0;
    logic [1:0]   Bresp = 2'b00;
    logic         Bvalid = 1'b0;

    logic [31:0] mem [0:1023];
    logic [31:0] shadow [0:1023];
    logic [31:0] pats [0:maxTests*6-1];
    logic [31:0] curResp = '0;
    logic        curStall = 1'b0;
    logic [31:0] gap;
    string       curName = "reset";
    integer      seed;
    int          errors = 0;
    int          checks = 0;
    bit          timedOut = 0;
    bit          rdActive = 0;
    bit          wrActive = 0;
    bit          bPending = 0;
    int          rdIdx;
    int          rdBeat;
    int          rdLen;
    int          wrIdx;
    int          wrBeat;
    int          wrLen;

    cacheAxiBridge i_cacheAxiBridge (
        .readSource (doneSource),
        .*
    );

    // whole address enters the fill
    function automatic logic [31:0] fillWord(input logic [31:0] s, input int i);
        return s ^ (32'(i) * 32'h9e3779b1);
    endfunction

    function automatic logic [31:0] lineWord(input logic [31:0] s, input int k);
        return ~s ^ (32'(k) * 32'h01000193) ^ 32'h5a5a5a5a;
    endfunction

    task automatic checkValue(input string name, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s: %s expected %h actual %h", name, what, expected, actual);
        end
    endtask

    task automatic reportTimeout(input string name, input string what);
        errors++;
        timedOut = 1;
        $display("%s: timed out waiting for %s", name, what);
    endtask

    task automatic runRead(input readSource src, input bit uncached, input logic [31:0] addr,
                           input logic expErr, input string name);
        int n;
        int wa;
        int k;
        bit got;
        n  = uncached ? 1 : ((src == SRC_ICACHE) ? icLineWords : dcLineWords);
        wa = int'(addr[11:2]);
        @(negedge Clk);
        if (src == SRC_ICACHE) begin
            icReadReq     = !uncached;
            icUncachedReq = uncached;
            icReadAddr    = addr;
        end else begin
            dcReadReq     = !uncached;
            dcUncachedReq = uncached;
            dcReadAddr    = addr;
        end
        got = 0;
        for (k = 0; k < waitLimit && !got; k++) begin
            @(posedge Clk);
            if ((src == SRC_ICACHE) ? icReadAccept : dcReadAccept) begin
                got = 1;
                checkValue(name, "Araddr", addr, Araddr);
                checkValue(name, "Arlen", n - 1, 32'(Arlen));
            end
        end
        if (!got) begin
            reportTimeout(name, "read accept");
            return;
        end
        @(negedge Clk);
        if (src == SRC_ICACHE) begin
            icReadReq     = 1'b0;
            icUncachedReq = 1'b0;
        end else begin
            dcReadReq     = 1'b0;
            dcUncachedReq = 1'b0;
        end
        got = 0;
        for (k = 0; k < waitLimit && !got; k++) begin
            @(posedge Clk);
            if (readDone) begin
                got = 1;
            end else if (icReadAccept || dcReadAccept) begin
                errors++;
                $display("%s: a read was accepted while another read was in flight", name);
            end
        end
        if (!got) begin
            reportTimeout(name, "readDone");
            return;
        end
        checkValue(name, "readSource", 32'(src), 32'(doneSource));
        checkValue(name, "readError", 32'(expErr), 32'(readError));
        for (k = 0; k < icLineWords; k++) begin
            checkValue(name, $sformatf("readLine word %0d", k),
                       (k < n) ? shadow[wa + k] : 32'd0, readLine[k*32 +: 32]);
        end
    endtask

    task automatic runWrite(input bit uncached, input logic [31:0] addr, input logic [31:0] s,
                            input logic [3:0] strb, input logic expErr, input string name);
        logic [255:0] line;
        int           wa;
        int           k;
        bit           got;
        wa = int'(addr[11:2]);
        for (k = 0; k < dcLineWords; k++) begin
            line[k*32 +: 32] = lineWord(s, k);
        end
        @(negedge Clk);
        dcWriteReq      = !uncached;
        dcWriteUncached = uncached;
        dcWriteAddr     = addr;
        dcWriteLine     = line;
        dcWriteStrb     = strb;
        got = 0;
        for (k = 0; k < waitLimit && !got; k++) begin
            @(posedge Clk);
            if (dcWriteAccept) begin
                got = 1;
                checkValue(name, "Awaddr", addr, Awaddr);
                checkValue(name, "Awlen", uncached ? 0 : dcLineWords - 1, 32'(Awlen));
            end
        end
        if (!got) begin
            reportTimeout(name, "dcWriteAccept");
            return;
        end
        @(negedge Clk);
        dcWriteReq      = 1'b0;
        dcWriteUncached = 1'b0;
        // old word with strobed bytes replaced, or the full line
        if (uncached) begin
            for (k = 0; k < 4; k++) begin
                if (strb[k]) shadow[wa][k*8 +: 8] = line[k*8 +: 8];
            end
        end else begin
            for (k = 0; k < dcLineWords; k++) begin
                shadow[wa + k] = line[k*32 +: 32];
            end
        end
        got = 0;
        for (k = 0; k < waitLimit && !got; k++) begin
            @(posedge Clk);
            if (writeDone) begin
                got = 1;
                checkValue(name, "writeError", 32'(expErr), 32'(writeError));
            end
        end
        if (!got) begin
            reportTimeout(name, "writeDone");
            return;
        end
        for (k = 0; k < dcLineWords; k++) begin
            checkValue(name, $sformatf("memory word %0d", wa + k), shadow[wa + k], mem[wa + k]);
        end
    endtask

    task automatic waitIdle(input string name);
        int k;
        bit got;
        got = 0;
        for (k = 0; k < waitLimit && !got; k++) begin
            @(posedge Clk);
            got = readIdle && writeIdle;
        end
        if (!got) reportTimeout(name, "both idle levels");
    endtask

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    // slave model sees handshakes at the rising edge
    always @(posedge Clk) begin
        if (!rstN) begin
            rdActive = 0;
            wrActive = 0;
            bPending = 0;
        end else begin
            if (Arvalid && Arready) begin
                rdIdx    = int'(Araddr[11:2]);
                rdLen    = int'(Arlen);
                rdBeat   = 0;
                rdActive = 1;
            end else if (Rvalid && Rready) begin
                if (Rlast) rdActive = 0;
                else rdBeat++;
            end
            if (Awvalid && Awready) begin
                wrIdx    = int'(Awaddr[11:2]);
                wrLen    = int'(Awlen);
                wrBeat   = 0;
                wrActive = 1;
            end else if (Wvalid && Wready) begin
                checkValue(curName, $sformatf("Wlast on beat %0d", wrBeat),
                           32'(wrBeat == wrLen), 32'(Wlast));
                for (int b = 0; b < 4; b++) begin
                    if (Wstrb[b]) mem[wrIdx + wrBeat][b*8 +: 8] = Wdata[b*8 +: 8];
                end
                if (Wlast) begin
                    wrActive = 0;
                    bPending = 1;
                end else begin
                    wrBeat++;
                end
            end
            if (Bvalid && Bready) bPending = 0;
        end
    end

    always @(negedge Clk) begin
        gap     = curStall ? $random(seed) : 32'hffffffff;
        Arready = !rdActive && gap[0];
        Rvalid  = rdActive && gap[1];
        Rdata   = mem[(rdIdx + rdBeat) % 1024];
        Rresp   = (rdBeat == 0) ? curResp[1:0] : 2'b00;
        Rlast   = rdActive && (rdBeat == rdLen);
        Awready = !wrActive && !bPending && gap[2];
        Wready  = wrActive && gap[3];
        Bvalid  = bPending && gap[4];
        Bresp   = curResp[1:0];
    end

    initial begin
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] dseed;
        logic        expErr;
        seed = 32'h15b092a6;
        rstN = 1'b0;
        icReadReq = 1'b0;
        icUncachedReq = 1'b0;
        icReadAddr = '0;
        dcReadReq = 1'b0;
        dcUncachedReq = 1'b0;
        dcReadAddr = '0;
        dcWriteReq = 1'b0;
        dcWriteUncached = 1'b0;
        dcWriteAddr = '0;
        dcWriteLine = '0;
        dcWriteStrb = '0;
        for (int i = 0; i < maxTests * 6; i++) pats[i] = '0;
        $readmemh("tb/cacheAxiBridge_patterns.txt", pats);
        repeat (8) @(posedge Clk);
        @(negedge Clk);
        rstN = 1'b1;
        @(posedge Clk);
        checkValue("reset", "readIdle", 1, 32'(readIdle));
        checkValue("reset", "writeIdle", 1, 32'(writeIdle));
        checkValue("reset", "valids", 0, 32'({Arvalid, Awvalid, Wvalid, Rready, Bready}));
        checkValue("reset", "pulses", 0, 32'({readDone, writeDone, dcWriteAccept}));
        for (int t = 0; t < maxTests; t++) begin
            op = pats[t*6];
            if (op == 0) break;
            addr     = pats[t*6 + 1];
            dseed    = pats[t*6 + 2];
            curResp  = pats[t*6 + 4];
            curStall = pats[t*6 + 5][0];
            expErr   = (curResp != 0);
            curName  = $sformatf("test %0d op %0d", t, op);
            for (int i = 0; i < 1024; i++) begin
                mem[i]    = fillWord(dseed, i);
                shadow[i] = mem[i];
            end
            case (op)
                1: runRead(SRC_ICACHE, 0, addr, expErr, curName);
                2: runRead(SRC_ICACHE, 1, addr, expErr, curName);
                3: runRead(SRC_DCACHE, 0, addr, expErr, curName);
                4: runRead(SRC_DCACHE, 1, addr, expErr, curName);
                5: runWrite(0, addr, dseed, pats[t*6 + 3][3:0], expErr, curName);
                6: runWrite(1, addr, dseed, pats[t*6 + 3][3:0], expErr, curName);
                // same-cycle requests with icache first
                7: fork
                    runRead(SRC_ICACHE, 0, addr, 0, curName);
                    runRead(SRC_DCACHE, 0, addr + 32'h100, 0, curName);
                join
                8: fork
                    runRead(SRC_DCACHE, 0, addr, 0, curName);
                    runWrite(0, addr + 32'h200, dseed, 4'hf, 0, curName);
                join
                default: begin
                    errors++;
                    $display("%s: unknown operation in the pattern file", curName);
                end
            endcase
            if (!timedOut) begin
                waitIdle(curName);
            end
            if (timedOut) begin
                break;
            end
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/cacheAxiBridge_patterns.txt
// op addr seed strobe resp stall, all hex, resp 2 forces SLVERR
// op 1 icLine 2 icUncached 3 dcLine 4 dcUncached 5 dcWrite 6 uncachedWrite 7 arbitrate 8 overlap
1 00000040 a5a50001 f 0 0
2 00000104 3c3c0002 f 0 0
3 00000220 5a5a0003 f 0 0
4 0000030c 12340004 f 0 0
5 00000400 deadbeef f 0 0
6 00000508 cafef00d 5 0 0
6 0000050c 0f0f1234 a 0 0
7 00000600 0bad0007 f 0 0
1 00000080 a5a50011 f 0 1
2 00000108 3c3c0012 f 0 1
3 00000240 5a5a0013 f 0 1
4 00000310 12340014 f 0 1
5 00000420 beefdead f 0 1
6 00000514 f00dcafe 3 0 1
7 00000640 0bad0017 f 0 1
8 00000700 77000018 f 0 1
1 000000c0 e0e00021 f 2 0
5 00000440 e0e00022 f 2 1
3 00000260 5a5a0023 f 0 0
0 00000000 00000000 0 0 0

// File: cacheAxiBridge.f
common/axiPkg.sv
common/cacheBusPkg.sv
common/readReqIf.sv
axiBridge/readArbiter.sv
axiBridge/axiReadEngine.sv
axiBridge/axiWriteEngine.sv
hdl/cacheAxiBridge.sv
tb/cacheAxiBridge_props.sv
tb/cacheAxiBridgeTb.sv

// File: Makefile
TOP := cacheAxiBridgeTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f cacheAxiBridge.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module cacheAxiBridge -f cacheAxiBridge.f

clean:
	rm -rf obj_dir sim.log
